//--- verilog/gnn_pkg.sv
package gnn_pkg;

    // lane and datapath widths
    localparam int FV_SIZE     = 8;
    localparam int MULT_PER_PE = 4;
    localparam int ACC_SIZE    = 24;
    // one value past MAX_FV must still fit
    localparam int IDX_SIZE    = 5;
    localparam int LAYER_SIZE  = 2;

    typedef enum logic [0:0] {
        IDLE = 1'b0,
        WORK = 1'b1
    } state_t;

    // start and end of stream marks toward the bank side
    typedef struct packed {
        logic sos;
        logic eos;
    } weight_cntl2bank_t;

    typedef struct packed {
        logic                  rd_en;
        logic [LAYER_SIZE-1:0] layer;
        logic [IDX_SIZE-1:0]   fv_base;
        logic                  last_of_layer;
    } lane_read_t;

    typedef struct packed {
        logic                                  valid;
        logic [MULT_PER_PE-1:0][FV_SIZE-1:0]   weights;
        logic [MULT_PER_PE-1:0][FV_SIZE-1:0]   features;
        logic [LAYER_SIZE-1:0]                 layer;
        logic                                  last_of_layer;
    } lane_data_t;

    typedef struct packed {
        logic                  wr_en;
        logic                  is_weight;
        logic [LAYER_SIZE-1:0] layer;
        logic [IDX_SIZE-1:0]   index;
        logic [FV_SIZE-1:0]    data;
    } host_wr_t;

endpackage

//--- verilog/weight_buffer.sv
`timescale 1ns/10ps

module weight_buffer import gnn_pkg::*; #(
    parameter int MAX_LAYERS = 4,
    parameter int MAX_FV     = 16
) (
    input  logic                                clk,
    input  logic                                reset,
    input  host_wr_t                            host_wr,
    input  lane_read_t                          rd,
    output logic [MULT_PER_PE-1:0][FV_SIZE-1:0] weights,
    output logic [LAYER_SIZE-1:0]               wt_layer,
    output logic                                wt_last,
    output logic                                wt_valid
);

    localparam int IW = $clog2(MAX_FV);

    // one weight per layer and feature index
    logic [MAX_LAYERS-1:0][MAX_FV-1:0][FV_SIZE-1:0] mem;

    always_ff @(posedge clk) begin
        if (reset) begin
            mem      <= '0;
            wt_valid <= 1'b0;
        end else begin
            if (host_wr.wr_en && host_wr.is_weight) begin
                mem[host_wr.layer][IW'(host_wr.index)] <= host_wr.data;
            end
            wt_valid <= rd.rd_en;
        end
    end

    // lane read with the request tag carried alongside
    always_ff @(posedge clk) begin
        if (rd.rd_en) begin
            for (int i = 0; i < MULT_PER_PE; i++) begin
                weights[i] <= mem[rd.layer][IW'(rd.fv_base + IDX_SIZE'(i))];
            end
            wt_layer <= rd.layer;
            wt_last  <= rd.last_of_layer;
        end
    end

endmodule

//--- verilog/weight_cntl.sv
`timescale 1ns/10ps

module weight_cntl import gnn_pkg::*; #(
    parameter int MAX_LAYERS = 4,
    parameter int MAX_FV     = 16
) (
    input  logic                   clk,
    input  logic                   reset,
    // number of layers minus one
    input  logic [LAYER_SIZE-1:0]  num_layers,
    input  logic [IDX_SIZE-1:0]    num_fv,
    input  logic                   fire,
    output lane_read_t             rd,
    output weight_cntl2bank_t      bank_marks,
    output logic                   rs_idle
);

    state_t                state, nx_state;
    logic [LAYER_SIZE-1:0] cur_layer, nx_layer;
    logic [IDX_SIZE-1:0]   cur_base, nx_base;
    logic [LAYER_SIZE-1:0] last_layer;
    logic [IDX_SIZE-1:0]   fv_end;
    logic                  end_of_layer;
    logic                  end_of_run;
    lane_read_t            nx_rd;
    weight_cntl2bank_t     nx_marks, marks_q;
    logic                  nx_idle;

    // keep the walk inside the buffer depth
    assign last_layer = (num_layers > LAYER_SIZE'(MAX_LAYERS - 1)) ?
                        LAYER_SIZE'(MAX_LAYERS - 1) : num_layers;
    assign fv_end     = (num_fv > IDX_SIZE'(MAX_FV)) ? IDX_SIZE'(MAX_FV) : num_fv;

    always_comb begin
        nx_state     = state;
        nx_layer     = cur_layer;
        nx_base      = cur_base;
        nx_rd        = '0;
        nx_marks     = '0;
        nx_idle      = 1'b0;
        end_of_layer = 1'b0;
        end_of_run   = 1'b0;
        case (state)
            IDLE: begin
                if (fire) begin
                    nx_state     = WORK;
                    nx_marks.sos = 1'b1;
                end else begin
                    nx_idle = 1'b1;
                end
            end
            WORK: begin
                end_of_layer        = (cur_base + IDX_SIZE'(MULT_PER_PE)) == fv_end;
                end_of_run          = end_of_layer && (cur_layer == last_layer);
                nx_rd.rd_en         = 1'b1;
                nx_rd.layer         = cur_layer;
                nx_rd.fv_base       = cur_base;
                nx_rd.last_of_layer = end_of_layer;
                if (end_of_layer) begin
                    nx_base  = '0;
                    nx_layer = cur_layer + 1'b1;
                end else begin
                    nx_base = cur_base + IDX_SIZE'(MULT_PER_PE);
                end
                // final beat of the final layer
                if (end_of_run) begin
                    nx_state     = IDLE;
                    nx_layer     = '0;
                    nx_marks.eos = 1'b1;
                end
            end
            default: nx_state = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= IDLE;
            cur_layer  <= '0;
            cur_base   <= '0;
            rd         <= '0;
            marks_q    <= '0;
            bank_marks <= '0;
            rs_idle    <= 1'b0;
        end else begin
            state      <= nx_state;
            cur_layer  <= nx_layer;
            cur_base   <= nx_base;
            rd         <= nx_rd;
            // marks go out two stages late
            marks_q    <= nx_marks;
            bank_marks <= marks_q;
            rs_idle    <= nx_idle;
        end
    end

endmodule

//--- verilog/feature_bank.sv
`timescale 1ns/10ps

module feature_bank import gnn_pkg::*; #(
    parameter int MAX_FV = 16
) (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                port_wr_en,
    input  logic [IDX_SIZE-1:0]                 port_wr_index,
    input  logic [FV_SIZE-1:0]                  port_wr_data,
    input  logic                                port_rd_en,
    input  logic [IDX_SIZE-1:0]                 port_rd_base,
    output logic [MULT_PER_PE-1:0][FV_SIZE-1:0] features
);

    localparam int IW = $clog2(MAX_FV);

    logic [MAX_FV-1:0][FV_SIZE-1:0] mem;

    // the one port goes to a read when both want it
    always_ff @(posedge clk) begin
        if (reset) begin
            mem <= '0;
        end else if (port_wr_en && !port_rd_en) begin
            mem[IW'(port_wr_index)] <= port_wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (port_rd_en) begin
            for (int i = 0; i < MULT_PER_PE; i++) begin
                features[i] <= mem[IW'(port_rd_base + IDX_SIZE'(i))];
            end
        end
    end

endmodule

//--- verilog/bank_arbiter.sv
`timescale 1ns/10ps

module bank_arbiter import gnn_pkg::*; (
    input  logic                clk,
    input  logic                reset,
    input  host_wr_t            host_wr,
    input  lane_read_t          rd,
    output logic                port_wr_en,
    output logic [IDX_SIZE-1:0] port_wr_index,
    output logic [FV_SIZE-1:0]  port_wr_data,
    output logic                port_rd_en,
    output logic [IDX_SIZE-1:0] port_rd_base
);

    logic                feat_wr;
    logic                pend_valid;
    logic [IDX_SIZE-1:0] pend_index;
    logic [FV_SIZE-1:0]  pend_data;

    assign feat_wr      = host_wr.wr_en && !host_wr.is_weight;
    assign port_rd_en   = rd.rd_en;
    assign port_rd_base = rd.fv_base;

    // reads win, then the parked write, then a direct one
    always_comb begin
        port_wr_en    = 1'b0;
        port_wr_index = host_wr.index;
        port_wr_data  = host_wr.data;
        if (!rd.rd_en) begin
            if (pend_valid) begin
                port_wr_en    = 1'b1;
                port_wr_index = pend_index;
                port_wr_data  = pend_data;
            end else begin
                port_wr_en = feat_wr;
            end
        end
    end

    // a write that cannot go now waits in the slot
    always_ff @(posedge clk) begin
        if (reset) begin
            pend_valid <= 1'b0;
        end else if (feat_wr && (rd.rd_en || pend_valid)) begin
            pend_valid <= 1'b1;
        end else if (!rd.rd_en) begin
            pend_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (feat_wr && (rd.rd_en || pend_valid)) begin
            pend_index <= host_wr.index;
            pend_data  <= host_wr.data;
        end
    end

endmodule

//--- verilog/vertex_mac.sv
`timescale 1ns/10ps

module vertex_mac import gnn_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  lane_data_t            beat,
    output logic                  result_valid,
    output logic [ACC_SIZE-1:0]   result,
    output logic [LAYER_SIZE-1:0] result_layer
);

    logic [ACC_SIZE-1:0] acc;
    logic [ACC_SIZE-1:0] beat_sum;
    logic [ACC_SIZE-1:0] total;

    // unsigned lane products of this beat
    always_comb begin
        beat_sum = '0;
        for (int i = 0; i < MULT_PER_PE; i++) begin
            beat_sum = beat_sum + ACC_SIZE'(beat.weights[i]) * ACC_SIZE'(beat.features[i]);
        end
    end

    assign total = acc + beat_sum;

    always_ff @(posedge clk) begin
        if (reset) begin
            acc          <= '0;
            result_valid <= 1'b0;
        end else begin
            result_valid <= beat.valid && beat.last_of_layer;
            if (beat.valid) begin
                // start clean for the next layer
                acc <= beat.last_of_layer ? '0 : total;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (beat.valid && beat.last_of_layer) begin
            result       <= total;
            result_layer <= beat.layer;
        end
    end

endmodule

//--- verilog/gnn_weight_top.sv
`timescale 1ns/10ps

module gnn_weight_top import gnn_pkg::*; #(
    parameter int MAX_LAYERS = 4,
    parameter int MAX_FV     = 16
) (
    input  logic                  clk,
    input  logic                  reset,
    input  host_wr_t              host_wr,
    input  logic [LAYER_SIZE-1:0] num_layers,
    input  logic [IDX_SIZE-1:0]   num_fv,
    input  logic                  fire,
    output logic                  result_valid,
    output logic [ACC_SIZE-1:0]   result,
    output logic [LAYER_SIZE-1:0] result_layer,
    output weight_cntl2bank_t     bank_marks,
    output logic                  rs_idle
);

    lane_read_t                          rd;
    lane_data_t                          beat;
    logic [MULT_PER_PE-1:0][FV_SIZE-1:0] weights;
    logic [MULT_PER_PE-1:0][FV_SIZE-1:0] features;
    logic [LAYER_SIZE-1:0]               wt_layer;
    logic                                wt_last;
    logic                                wt_valid;
    logic                                port_wr_en;
    logic [IDX_SIZE-1:0]                 port_wr_index;
    logic [FV_SIZE-1:0]                  port_wr_data;
    logic                                port_rd_en;
    logic [IDX_SIZE-1:0]                 port_rd_base;

    weight_cntl #(.MAX_LAYERS(MAX_LAYERS), .MAX_FV(MAX_FV)) u_cntl (
        .clk(clk), .reset(reset), .num_layers(num_layers), .num_fv(num_fv),
        .fire(fire), .rd(rd), .bank_marks(bank_marks), .rs_idle(rs_idle)
    );

    weight_buffer #(.MAX_LAYERS(MAX_LAYERS), .MAX_FV(MAX_FV)) u_wbuf (
        .clk(clk), .reset(reset), .host_wr(host_wr), .rd(rd), .weights(weights),
        .wt_layer(wt_layer), .wt_last(wt_last), .wt_valid(wt_valid)
    );

    bank_arbiter u_arb (
        .clk(clk), .reset(reset), .host_wr(host_wr), .rd(rd),
        .port_wr_en(port_wr_en), .port_wr_index(port_wr_index),
        .port_wr_data(port_wr_data), .port_rd_en(port_rd_en),
        .port_rd_base(port_rd_base)
    );

    feature_bank #(.MAX_FV(MAX_FV)) u_bank (
        .clk(clk), .reset(reset), .port_wr_en(port_wr_en),
        .port_wr_index(port_wr_index), .port_wr_data(port_wr_data),
        .port_rd_en(port_rd_en), .port_rd_base(port_rd_base), .features(features)
    );

    // both fragments land on the same edge
    assign beat.valid         = wt_valid;
    assign beat.weights       = weights;
    assign beat.features      = features;
    assign beat.layer         = wt_layer;
    assign beat.last_of_layer = wt_last;

    vertex_mac u_mac (
        .clk(clk), .reset(reset), .beat(beat), .result_valid(result_valid),
        .result(result), .result_layer(result_layer)
    );

endmodule

//--- sim/tb_clock.sv
`timescale 1ns/10ps

module tb_clock #(
    parameter int HALF_PERIOD = 4
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

endmodule

//--- sim/gnn_weight_sva.sv
`timescale 1ns/10ps

module gnn_weight_sva import gnn_pkg::*; (
    input logic              clk,
    input logic              reset,
    input logic              fire,
    input logic              result_valid,
    input logic              rs_idle,
    input weight_cntl2bank_t bank_marks
);

    localparam int EOS_LIMIT = 40;

    int   overlap_fails = 0;
    int   idle_fails    = 0;
    int   eos_fails     = 0;
    logic run_open;
    int   open_cycles;

    // a fire taken in idle opens a run until its eos
    always_ff @(posedge clk) begin
        if (reset) begin
            run_open    <= 1'b0;
            open_cycles <= 0;
        end else if (fire && rs_idle) begin
            run_open    <= 1'b1;
            open_cycles <= 0;
        end else if (bank_marks.eos) begin
            run_open <= 1'b0;
        end else if (run_open) begin
            open_cycles <= open_cycles + 1;
        end
    end

    assert property (@(posedge clk) disable iff (reset) !(bank_marks.sos && bank_marks.eos))
        else begin
            $error("sos and eos high in the same cycle");
            overlap_fails++;
        end

    // only the final layer may land after idle is back, right behind eos
    assert property (@(posedge clk) disable iff (reset)
        (result_valid && rs_idle) |-> $past(bank_marks.eos))
        else begin
            $error("result_valid while rs_idle is high");
            idle_fails++;
        end

    assert property (@(posedge clk) disable iff (reset) !(run_open && open_cycles > EOS_LIMIT))
        else begin
            $error("no eos within the cycle limit after fire");
            eos_fails++;
        end

endmodule

bind gnn_weight_top gnn_weight_sva u_sva (
    .clk(clk), .reset(reset), .fire(fire), .result_valid(result_valid),
    .rs_idle(rs_idle), .bank_marks(bank_marks)
);

//--- sim/gnn_weight_tb.sv
`timescale 1ns/10ps

module gnn_weight_tb import gnn_pkg::*; ();

    localparam int MAX_LAYERS = 4;
    localparam int MAX_FV     = 16;
    localparam int IW         = $clog2(MAX_FV);
    localparam int LATE_IDX   = 2;

    logic                  clk;
    logic                  reset;
    logic                  fire;
    host_wr_t              host_wr;
    logic [LAYER_SIZE-1:0] num_layers;
    logic [IDX_SIZE-1:0]   num_fv;
    logic                  result_valid;
    logic [ACC_SIZE-1:0]   result;
    logic [LAYER_SIZE-1:0] result_layer;
    weight_cntl2bank_t     bank_marks;
    logic                  rs_idle;

    // reference copy of what the host wrote
    logic [FV_SIZE-1:0] ref_wt [MAX_LAYERS][MAX_FV];
    logic [FV_SIZE-1:0] ref_ft [MAX_FV];
    logic [15:0]        lfsr;
    logic [FV_SIZE-1:0] v;
    int                 cyc;
    int                 value_errors;
    int                 timeout_errors;
    int                 sva_errors;
    int                 n;

    tb_clock #(.HALF_PERIOD(4)) u_clock (.clk(clk));

    gnn_weight_top #(.MAX_LAYERS(MAX_LAYERS), .MAX_FV(MAX_FV)) uut (
        .clk(clk), .reset(reset), .host_wr(host_wr), .num_layers(num_layers),
        .num_fv(num_fv), .fire(fire), .result_valid(result_valid), .result(result),
        .result_layer(result_layer), .bank_marks(bank_marks), .rs_idle(rs_idle)
    );

    // taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic rand_byte(output logic [FV_SIZE-1:0] b);
        b = '0;
        for (int i = 0; i < FV_SIZE; i++) begin
            lfsr = lfsr_step(lfsr);
            b    = {b[FV_SIZE-2:0], lfsr[0]};
        end
    endtask

    function automatic logic [ACC_SIZE-1:0] layer_dot(input int layer, input int nfv);
        logic [ACC_SIZE-1:0] sum;
        sum = '0;
        for (int i = 0; i < nfv; i++) begin
            sum = sum + ACC_SIZE'(ref_wt[LAYER_SIZE'(layer)][IW'(i)]) * ACC_SIZE'(ref_ft[IW'(i)]);
        end
        return sum;
    endfunction

    // one edge, then sit 1 ns past it
    task automatic step();
        @(posedge clk);
        #1;
        cyc++;
    endtask

    task automatic check_value(input string what, input int got, input int exp);
        assert (got == exp) else begin
            value_errors++;
            $display("ERR %0t %s: got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic report_timeout(input string what);
        timeout_errors++;
        $display("timed out waiting for %s", what);
    endtask

    task automatic host_write(input logic is_weight, input int layer, input int index,
                              input logic [FV_SIZE-1:0] data);
        host_wr.wr_en     = 1'b1;
        host_wr.is_weight = is_weight;
        host_wr.layer     = LAYER_SIZE'(layer);
        host_wr.index     = IDX_SIZE'(index);
        host_wr.data      = data;
        step();
        host_wr = '0;
    endtask

    task automatic run_layers(input int layers, input int nfv, input bit extra_fire,
                              input bit late_write);
        logic [ACC_SIZE-1:0] exp_res [MAX_LAYERS];
        logic [FV_SIZE-1:0]  late_data;
        int                  k;
        int                  t;
        int                  got;
        int                  cnt;
        int                  sos_cyc;
        int                  eos_cyc;
        k         = nfv / MULT_PER_PE;
        late_data = ref_ft[IW'(LATE_IDX)] ^ 8'h5a;
        for (int l = 0; l < layers; l++) begin
            exp_res[LAYER_SIZE'(l)] = layer_dot(l, nfv);
        end
        num_layers = LAYER_SIZE'(layers - 1);
        num_fv     = IDX_SIZE'(nfv);
        fire       = 1'b1;
        step();
        fire    = 1'b0;
        t       = cyc;
        got     = 0;
        cnt     = 0;
        sos_cyc = -1;
        eos_cyc = -1;
        while (got < layers && cnt < 100) begin
            step();
            cnt++;
            host_wr = '0;
            fire    = extra_fire && (cyc == t + 2);
            // a feature write that has to wait for the bank
            if (late_write && cyc == t + 3) begin
                host_wr.wr_en = 1'b1;
                host_wr.index = IDX_SIZE'(LATE_IDX);
                host_wr.data  = late_data;
            end
            if (bank_marks.sos) sos_cyc = cyc;
            if (bank_marks.eos) eos_cyc = cyc;
            if (result_valid) begin
                check_value("result layer", int'(result_layer), got);
                check_value("result", int'(result), int'(exp_res[LAYER_SIZE'(got)]));
                check_value("result edge", cyc, t + k + 2 + got * k);
                got++;
            end
        end
        if (got < layers) report_timeout("layer results");
        host_wr = '0;
        fire    = 1'b0;
        check_value("sos edge", sos_cyc, t + 1);
        check_value("eos edge", eos_cyc, t + k * layers + 1);
        // nothing more may follow the run
        repeat (6) begin
            step();
            check_value("late result_valid", int'(result_valid), 0);
            check_value("late marks", int'(bank_marks), 0);
        end
        check_value("rs_idle after run", int'(rs_idle), 1);
        if (late_write) ref_ft[IW'(LATE_IDX)] = late_data;
    endtask

    initial begin
        reset          = 1'b1;
        fire           = 1'b0;
        host_wr        = '0;
        num_layers     = '0;
        num_fv         = '0;
        lfsr           = 16'd87;
        cyc            = 0;
        value_errors   = 0;
        timeout_errors = 0;
        repeat (10) step();
        check_value("rs_idle in reset", int'(rs_idle), 0);
        check_value("result_valid in reset", int'(result_valid), 0);
        check_value("marks in reset", int'(bank_marks), 0);
        reset = 1'b0;
        n     = 0;
        while (!rs_idle && n < 20) begin
            step();
            n++;
        end
        if (!rs_idle) report_timeout("rs_idle after reset");
        for (int l = 0; l < MAX_LAYERS; l++) begin
            for (int i = 0; i < MAX_FV; i++) begin
                rand_byte(v);
                ref_wt[LAYER_SIZE'(l)][IW'(i)] = v;
                host_write(1'b1, l, i, v);
            end
        end
        for (int i = 0; i < MAX_FV; i++) begin
            rand_byte(v);
            ref_ft[IW'(i)] = v;
            host_write(1'b0, 0, i, v);
        end
        run_layers(4, 16, 1'b1, 1'b0);
        run_layers(2, 8, 1'b0, 1'b1);
        run_layers(4, 16, 1'b0, 1'b0);
        run_layers(2, 8, 1'b0, 1'b0);
        sva_errors = uut.u_sva.overlap_fails + uut.u_sva.idle_fails + uut.u_sva.eos_fails;
        $display("value errors %0d, timeout errors %0d, assertion errors %0d",
                 value_errors, timeout_errors, sva_errors);
        if (value_errors + timeout_errors + sva_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- filelist.f
verilog/gnn_pkg.sv
verilog/weight_buffer.sv
verilog/weight_cntl.sv
verilog/feature_bank.sv
verilog/bank_arbiter.sv
verilog/vertex_mac.sv
verilog/gnn_weight_top.sv
sim/tb_clock.sv
sim/gnn_weight_sva.sv
sim/gnn_weight_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= gnn_weight_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
RUN_ARGS  ?= +verilator+error+limit+1000

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Testbench failed" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "Testbench passed" $(LOG) || { echo "no pass line in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
